/* common/bridge_pkg.sv */
// Bridge subsystem definitions
`default_nettype none

package bridge_pkg;

    // Bus widths.
    localparam int addr_w = 32;     // Byte address.
    localparam int data_w = 32;
    localparam int strb_w = 4;      // One strobe per byte lane.

    // Memory geometry.
    localparam int mem_words = 256;
    localparam int mem_idx_w = 8;   // Word index, log2 of mem_words.

    // Avalon-MM response codes.
    typedef enum logic [1:0] {
        RESP_OKAY        = 2'b00,
        RESP_RESERVED    = 2'b01,
        RESP_SLVERROR    = 2'b10,
        RESP_DECODEERROR = 2'b11
    } avalon_resp_t;

    // AXI response codes.
    typedef enum logic [1:0] {
        AXI_OKAY   = 2'b00,
        AXI_EXOKAY = 2'b01,   // Never produced, no exclusive access.
        AXI_SLVERR = 2'b10,
        AXI_DECERR = 2'b11
    } axi_resp_t;

    // Arbiter FSM.
    typedef enum logic {
        ARB_IDLE = 1'b0,   // Waiting for a request.
        ARB_BUSY = 1'b1    // Owner holds the bus until its response.
    } arb_state_t;

endpackage

`default_nettype wire

/* axi_to_avalon/axi_to_avalon_bridge.sv */
// AXI4-Lite to Avalon-MM bridge
`timescale 1ns/1ps
`default_nettype none

module axi_to_avalon_bridge import bridge_pkg::*; (
    input  wire                 aclk,
    input  wire                 areset_n,
    // AXI4-Lite subordinate side.
    input  wire                 awvalid,
    output logic                awready,
    input  wire  [addr_w-1:0]   awaddr,
    input  wire  [2:0]          awprot,       // Ignored.
    input  wire                 wvalid,
    output logic                wready,
    input  wire  [data_w-1:0]   wdata,
    input  wire  [strb_w-1:0]   wstrb,
    output logic                bvalid,
    input  wire                 bready,
    output axi_resp_t           bresp,
    input  wire                 arvalid,
    output logic                arready,
    input  wire  [addr_w-1:0]   araddr,
    input  wire  [2:0]          arprot,       // Ignored.
    output logic                rvalid,
    input  wire                 rready,
    output logic [data_w-1:0]   rdata,
    output axi_resp_t           rresp,
    // Avalon-MM host side.
    output logic                read,
    output logic                write,
    output logic [addr_w-1:0]   address,
    output logic [strb_w-1:0]   byteenable,
    output logic [data_w-1:0]   writedata,
    input  wire                 waitrequest,
    input  wire                 readdatavalid,
    input  wire                 writeresponsevalid,
    input  wire  [data_w-1:0]   readdata,
    input  wire avalon_resp_t   response
);
    logic      pending;       // One transaction in flight.
    logic      ready_q;       // Request channels open.
    logic      wr_req;
    logic      accept_wr;
    logic      accept_rd;
    logic      resp_taken;
    axi_resp_t resp_decoded;

    assign wr_req     = awvalid && wvalid;            // Address and data both present.
    assign accept_wr  = ready_q && wr_req;
    assign accept_rd  = arready && arvalid;
    assign awready    = accept_wr;                    // Raised together with wready.
    assign wready     = accept_wr;
    assign arready    = ready_q && !awvalid;          // A pending write wins.
    assign resp_taken = (bvalid && bready) || (rvalid && rready);

    // Avalon to AXI response code.
    always_comb begin
        case (response)
            RESP_OKAY:        resp_decoded = AXI_OKAY;
            RESP_DECODEERROR: resp_decoded = AXI_DECERR;
            default:          resp_decoded = AXI_SLVERR;
        endcase
    end

    // Blocks new requests until the response is handed over.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            pending <= 1'b0;
            ready_q <= 1'b0;                          // Opens one cycle after reset.
        end else begin
            if (accept_wr || accept_rd)
                pending <= 1'b1;
            else if (resp_taken)
                pending <= 1'b0;
            ready_q <= !(accept_wr || accept_rd || (pending && !resp_taken));
        end
    end

    // Command strobes held while waitrequest is high.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            write <= 1'b0;
            read  <= 1'b0;
        end else if (accept_wr || accept_rd) begin
            write <= accept_wr;
            read  <= accept_rd;
        end else if (!waitrequest) begin          // Agent took the command.
            write <= 1'b0;
            read  <= 1'b0;
        end
    end

    // Command payload.
    always_ff @(posedge aclk) begin
        if (accept_wr) begin
            address    <= awaddr;
            byteenable <= wstrb;
            writedata  <= wdata;
        end else if (accept_rd) begin
            address    <= araddr;
            byteenable <= '1;                         // Reads fetch the full word.
        end
    end

    // Write response held until bready.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n)
            bvalid <= 1'b0;
        else if (writeresponsevalid)
            bvalid <= 1'b1;
        else if (bready)
            bvalid <= 1'b0;
    end

    // Read response held until rready.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n)
            rvalid <= 1'b0;
        else if (readdatavalid)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;
    end

    always_ff @(posedge aclk) begin
        if (writeresponsevalid)
            bresp <= resp_decoded;
        if (readdatavalid) begin
            rdata <= readdata;
            rresp <= resp_decoded;
        end
    end

endmodule

`default_nettype wire

/* logic/avalon_arbiter.sv */
// Two-host Avalon-MM round-robin arbiter
`timescale 1ns/1ps
`default_nettype none

module avalon_arbiter import bridge_pkg::*; (
    input  wire                 aclk,
    input  wire                 areset_n,
    // Host 0.
    input  wire                 h0_read,
    input  wire                 h0_write,
    input  wire  [addr_w-1:0]   h0_address,
    input  wire  [strb_w-1:0]   h0_byteenable,
    input  wire  [data_w-1:0]   h0_writedata,
    output logic                h0_waitrequest,
    output logic                h0_readdatavalid,
    output logic                h0_writeresponsevalid,
    output logic [data_w-1:0]   h0_readdata,
    output avalon_resp_t        h0_response,
    // Host 1.
    input  wire                 h1_read,
    input  wire                 h1_write,
    input  wire  [addr_w-1:0]   h1_address,
    input  wire  [strb_w-1:0]   h1_byteenable,
    input  wire  [data_w-1:0]   h1_writedata,
    output logic                h1_waitrequest,
    output logic                h1_readdatavalid,
    output logic                h1_writeresponsevalid,
    output logic [data_w-1:0]   h1_readdata,
    output avalon_resp_t        h1_response,
    // Shared agent.
    output logic                m_read,
    output logic                m_write,
    output logic [addr_w-1:0]   m_address,
    output logic [strb_w-1:0]   m_byteenable,
    output logic [data_w-1:0]   m_writedata,
    input  wire                 m_waitrequest,
    input  wire                 m_readdatavalid,
    input  wire                 m_writeresponsevalid,
    input  wire  [data_w-1:0]   m_readdata,
    input  wire avalon_resp_t   m_response
);
    arb_state_t state;
    logic       last;           // Host served last, owner while busy.
    logic       busy;
    logic       h0_req;
    logic       h1_req;
    logic       grant;
    logic       resp_pulse;

    assign h0_req     = h0_read || h0_write;
    assign h1_req     = h1_read || h1_write;
    assign grant      = (h0_req && h1_req) ? !last : h1_req;  // Tie goes to the other host.
    assign busy       = (state == ARB_BUSY);
    assign resp_pulse = m_readdatavalid || m_writeresponsevalid;

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            state <= ARB_IDLE;
            last  <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (h0_req || h1_req) begin
                        state <= ARB_BUSY;
                        last  <= grant;
                    end
                end
                ARB_BUSY: begin
                    if (resp_pulse)
                        state <= ARB_IDLE;            // Free on the response cycle.
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Owner's command goes straight through.
    always_comb begin
        m_address    = last ? h1_address    : h0_address;
        m_byteenable = last ? h1_byteenable : h0_byteenable;
        m_writedata  = last ? h1_writedata  : h0_writedata;
        m_read       = busy && (last ? h1_read  : h0_read);
        m_write      = busy && (last ? h1_write : h0_write);
    end

    // Everyone but the owner waits.
    assign h0_waitrequest = !busy || last  || m_waitrequest;
    assign h1_waitrequest = !busy || !last || m_waitrequest;

    // Response pulses only to the owner. Payload is shared.
    assign h0_readdatavalid      = busy && !last && m_readdatavalid;
    assign h0_writeresponsevalid = busy && !last && m_writeresponsevalid;
    assign h1_readdatavalid      = busy && last && m_readdatavalid;
    assign h1_writeresponsevalid = busy && last && m_writeresponsevalid;
    assign h0_readdata           = m_readdata;
    assign h1_readdata           = m_readdata;
    assign h0_response           = m_response;
    assign h1_response           = m_response;

endmodule

`default_nettype wire

/* logic/avalon_memory.sv */
// Avalon-MM word memory
`timescale 1ns/1ps
`default_nettype none

module avalon_memory import bridge_pkg::*; (
    input  wire                 aclk,
    input  wire                 areset_n,
    input  wire                 read,
    input  wire                 write,
    input  wire  [addr_w-1:0]   address,
    input  wire  [strb_w-1:0]   byteenable,
    input  wire  [data_w-1:0]   writedata,
    output logic                waitrequest,
    output logic                readdatavalid,
    output logic                writeresponsevalid,
    output logic [data_w-1:0]   readdata,
    output avalon_resp_t        response
);
    logic [data_w-1:0]    mem [mem_words];
    logic                 wait_done;      // Wait state served.
    logic                 cmd;
    logic                 accept;
    logic [addr_w-3:0]    word_addr;
    logic [mem_idx_w-1:0] idx;
    logic                 in_range;

    assign cmd         = read || write;
    assign waitrequest = cmd && !wait_done;       // First cycle of every command.
    assign accept      = cmd && wait_done;
    assign word_addr   = address[addr_w-1:2];     // Byte offset dropped.
    assign idx         = word_addr[mem_idx_w-1:0];
    assign in_range    = (word_addr < (addr_w-2)'(mem_words));

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n)
            wait_done <= 1'b0;
        else
            wait_done <= cmd && !wait_done;       // Clears on acceptance.
    end

    // Response strobes, one cycle after acceptance.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            readdatavalid      <= 1'b0;
            writeresponsevalid <= 1'b0;
        end else begin
            readdatavalid      <= accept && read;
            writeresponsevalid <= accept && write;
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            readdata <= (read && in_range) ? mem[idx] : '0;
            response <= in_range ? RESP_OKAY : RESP_DECODEERROR;
        end
    end

    // Lane-wise write. Out of range leaves storage alone.
    always_ff @(posedge aclk) begin
        if (accept && write && in_range) begin
            for (int i = 0; i < strb_w; i++) begin
                if (byteenable[i])
                    mem[idx][8*i +: 8] <= writedata[8*i +: 8];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/bridge_top.sv */
// Dual AXI4-Lite shared memory subsystem
`timescale 1ns/1ps
`default_nettype none

module bridge_top import bridge_pkg::*; (
    input  wire                 aclk,
    input  wire                 areset_n,
    // Port 0.
    input  wire                 s0_awvalid,
    output logic                s0_awready,
    input  wire  [addr_w-1:0]   s0_awaddr,
    input  wire  [2:0]          s0_awprot,
    input  wire                 s0_wvalid,
    output logic                s0_wready,
    input  wire  [data_w-1:0]   s0_wdata,
    input  wire  [strb_w-1:0]   s0_wstrb,
    output logic                s0_bvalid,
    input  wire                 s0_bready,
    output axi_resp_t           s0_bresp,
    input  wire                 s0_arvalid,
    output logic                s0_arready,
    input  wire  [addr_w-1:0]   s0_araddr,
    input  wire  [2:0]          s0_arprot,
    output logic                s0_rvalid,
    input  wire                 s0_rready,
    output logic [data_w-1:0]   s0_rdata,
    output axi_resp_t           s0_rresp,
    // Port 1.
    input  wire                 s1_awvalid,
    output logic                s1_awready,
    input  wire  [addr_w-1:0]   s1_awaddr,
    input  wire  [2:0]          s1_awprot,
    input  wire                 s1_wvalid,
    output logic                s1_wready,
    input  wire  [data_w-1:0]   s1_wdata,
    input  wire  [strb_w-1:0]   s1_wstrb,
    output logic                s1_bvalid,
    input  wire                 s1_bready,
    output axi_resp_t           s1_bresp,
    input  wire                 s1_arvalid,
    output logic                s1_arready,
    input  wire  [addr_w-1:0]   s1_araddr,
    input  wire  [2:0]          s1_arprot,
    output logic                s1_rvalid,
    input  wire                 s1_rready,
    output logic [data_w-1:0]   s1_rdata,
    output axi_resp_t           s1_rresp
);
    // Bridge to arbiter, per host.
    logic               h0_read, h0_write, h0_waitrequest;
    logic               h0_readdatavalid, h0_writeresponsevalid;
    logic [addr_w-1:0]  h0_address;
    logic [strb_w-1:0]  h0_byteenable;
    logic [data_w-1:0]  h0_writedata, h0_readdata;
    avalon_resp_t       h0_response;
    logic               h1_read, h1_write, h1_waitrequest;
    logic               h1_readdatavalid, h1_writeresponsevalid;
    logic [addr_w-1:0]  h1_address;
    logic [strb_w-1:0]  h1_byteenable;
    logic [data_w-1:0]  h1_writedata, h1_readdata;
    avalon_resp_t       h1_response;

    // Arbiter to memory.
    logic               m_read, m_write, m_waitrequest;
    logic               m_readdatavalid, m_writeresponsevalid;
    logic [addr_w-1:0]  m_address;
    logic [strb_w-1:0]  m_byteenable;
    logic [data_w-1:0]  m_writedata, m_readdata;
    avalon_resp_t       m_response;

    axi_to_avalon_bridge i_bridge0 (
        .aclk(aclk), .areset_n(areset_n),
        .awvalid(s0_awvalid), .awready(s0_awready), .awaddr(s0_awaddr), .awprot(s0_awprot),
        .wvalid(s0_wvalid), .wready(s0_wready), .wdata(s0_wdata), .wstrb(s0_wstrb),
        .bvalid(s0_bvalid), .bready(s0_bready), .bresp(s0_bresp),
        .arvalid(s0_arvalid), .arready(s0_arready), .araddr(s0_araddr), .arprot(s0_arprot),
        .rvalid(s0_rvalid), .rready(s0_rready), .rdata(s0_rdata), .rresp(s0_rresp),
        .read(h0_read), .write(h0_write), .address(h0_address),
        .byteenable(h0_byteenable), .writedata(h0_writedata),
        .waitrequest(h0_waitrequest), .readdatavalid(h0_readdatavalid),
        .writeresponsevalid(h0_writeresponsevalid),
        .readdata(h0_readdata), .response(h0_response)
    );

    axi_to_avalon_bridge i_bridge1 (
        .aclk(aclk), .areset_n(areset_n),
        .awvalid(s1_awvalid), .awready(s1_awready), .awaddr(s1_awaddr), .awprot(s1_awprot),
        .wvalid(s1_wvalid), .wready(s1_wready), .wdata(s1_wdata), .wstrb(s1_wstrb),
        .bvalid(s1_bvalid), .bready(s1_bready), .bresp(s1_bresp),
        .arvalid(s1_arvalid), .arready(s1_arready), .araddr(s1_araddr), .arprot(s1_arprot),
        .rvalid(s1_rvalid), .rready(s1_rready), .rdata(s1_rdata), .rresp(s1_rresp),
        .read(h1_read), .write(h1_write), .address(h1_address),
        .byteenable(h1_byteenable), .writedata(h1_writedata),
        .waitrequest(h1_waitrequest), .readdatavalid(h1_readdatavalid),
        .writeresponsevalid(h1_writeresponsevalid),
        .readdata(h1_readdata), .response(h1_response)
    );

    avalon_arbiter i_arbiter (
        .aclk(aclk), .areset_n(areset_n),
        .h0_read(h0_read), .h0_write(h0_write), .h0_address(h0_address),
        .h0_byteenable(h0_byteenable), .h0_writedata(h0_writedata),
        .h0_waitrequest(h0_waitrequest), .h0_readdatavalid(h0_readdatavalid),
        .h0_writeresponsevalid(h0_writeresponsevalid),
        .h0_readdata(h0_readdata), .h0_response(h0_response),
        .h1_read(h1_read), .h1_write(h1_write), .h1_address(h1_address),
        .h1_byteenable(h1_byteenable), .h1_writedata(h1_writedata),
        .h1_waitrequest(h1_waitrequest), .h1_readdatavalid(h1_readdatavalid),
        .h1_writeresponsevalid(h1_writeresponsevalid),
        .h1_readdata(h1_readdata), .h1_response(h1_response),
        .m_read(m_read), .m_write(m_write), .m_address(m_address),
        .m_byteenable(m_byteenable), .m_writedata(m_writedata),
        .m_waitrequest(m_waitrequest), .m_readdatavalid(m_readdatavalid),
        .m_writeresponsevalid(m_writeresponsevalid),
        .m_readdata(m_readdata), .m_response(m_response)
    );

    avalon_memory i_memory (
        .aclk(aclk), .areset_n(areset_n),
        .read(m_read), .write(m_write), .address(m_address),
        .byteenable(m_byteenable), .writedata(m_writedata),
        .waitrequest(m_waitrequest), .readdatavalid(m_readdatavalid),
        .writeresponsevalid(m_writeresponsevalid),
        .readdata(m_readdata), .response(m_response)
    );

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic aclk,
    output logic areset_n
);
    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;          // 8 ns period.
    end

    initial begin
        areset_n = 1'b0;
        repeat (8) @(posedge aclk);       // Eight cycles in reset.
        @(negedge aclk);                  // Released on a falling edge.
        areset_n = 1'b1;
    end
endmodule

`default_nettype wire

/* bench/tb_bridge_top.sv */
// Dual port bridge testbench
`timescale 1ns/1ps
`default_nettype none

module axi_lite_traffic import bridge_pkg::*; (
    input  wire               aclk,
    input  wire               areset_n,
    input  wire               half,            // Memory half owned by this port.
    input  wire [15:0]        trans_count,
    output logic              awvalid,
    input  wire               awready,
    output logic [addr_w-1:0] awaddr,
    output logic [2:0]        awprot,
    output logic              wvalid,
    input  wire               wready,
    output logic [data_w-1:0] wdata,
    output logic [strb_w-1:0] wstrb,
    input  wire               bvalid,
    output logic              bready,
    input  wire axi_resp_t    bresp,
    output logic              arvalid,
    input  wire               arready,
    output logic [addr_w-1:0] araddr,
    output logic [2:0]        arprot,
    input  wire               rvalid,
    output logic              rready,
    input  wire [data_w-1:0]  rdata,
    input  wire axi_resp_t    rresp,
    output logic              done,
    output int                errors
);
    typedef struct packed {
        logic              is_wr;
        axi_resp_t         resp;
        logic [data_w-1:0] data;
        logic [strb_w-1:0] known;             // Lanes written so far.
    } expect_t;

    logic [data_w-1:0] model_mem   [mem_words];
    logic [strb_w-1:0] model_known [mem_words];
    expect_t           exp_q [$];            // Filled at each request handshake.
    int                checked;              // Responses compared so far.

    assign done = (checked == int'(trans_count));

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic masked_equal(input logic [data_w-1:0] a, input logic [data_w-1:0] b,
                                          input logic [strb_w-1:0] known);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < strb_w; i++)
            if (known[i] && (a[8*i +: 8] !== b[8*i +: 8]))
                ok = 1'b0;
        return ok;
    endfunction

    // Memory model. Bytes below mem_words*4 exist, everything else decodes to nothing.
    function automatic expect_t model_access(input logic is_wr, input logic [addr_w-1:0] addr,
                                             input logic [data_w-1:0] data,
                                             input logic [strb_w-1:0] strb);
        expect_t              e;
        logic [mem_idx_w-1:0] idx;
        e.is_wr = is_wr;
        e.data  = '0;
        e.known = '0;                         // Nothing to compare by default.
        idx     = addr[mem_idx_w+1:2];
        if (addr >= 32'(mem_words * 4)) begin
            e.resp = AXI_DECERR;
        end else begin
            e.resp = AXI_OKAY;
            if (is_wr) begin
                for (int i = 0; i < strb_w; i++) begin
                    if (strb[i]) begin
                        model_mem[idx][8*i +: 8] = data[8*i +: 8];
                        model_known[idx][i]      = 1'b1;
                    end
                end
            end else begin
                e.data  = model_mem[idx];
                e.known = model_known[idx];
            end
        end
        return e;
    endfunction

    task automatic check_response(input logic is_wr, input axi_resp_t resp,
                                  input logic [data_w-1:0] data);
        expect_t e;
        assert (checked < exp_q.size()) else begin
            errors++;
            $display("Port %0d returned a response at %0t with no request outstanding",
                     half, $time);
        end
        if (checked < exp_q.size()) begin
            e = exp_q[checked];
            checked++;
            assert (e.is_wr == is_wr) else begin
                errors++;
                $display("error %0t: port %0d response kind write=%0b, expected write=%0b",
                         $time, half, is_wr, e.is_wr);
            end
            assert (resp === e.resp) else begin
                errors++;
                $display("error %0t: port %0d response %s, expected %s",
                         $time, half, resp.name(), e.resp.name());
            end
            if (!is_wr)
                assert (masked_equal(data, e.data, e.known)) else begin
                    errors++;
                    $display("error %0t: port %0d read data %h, expected %h (lanes %b)",
                             $time, half, data, e.data, e.known);
                end
        end
    endtask

    // Request driver. Inputs change on falling edges, readies are sampled 2 ns later.
    initial begin : drive
        logic [31:0]       st;
        logic [31:0]       r;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic              is_wr;
        logic              accepted;
        awvalid     = 1'b0;
        wvalid      = 1'b0;
        arvalid     = 1'b0;
        awaddr      = '0;
        araddr      = '0;
        awprot      = 3'b000;
        arprot      = 3'b000;
        wdata       = '0;
        wstrb       = '0;
        model_known = '{default: '0};
        @(posedge areset_n);
        st = 32'd74 + 32'(half);
        for (int n = 0; n < int'(trans_count); n++) begin
            st    = lcg_next(st);
            r     = st;
            st    = lcg_next(st);
            data  = st;
            is_wr = r[24];
            strb  = r[25] ? 4'hf : r[29:26];  // Half full, half partial.
            addr  = {22'd0, half, 2'b00, r[20:16], 2'b00};  // 32 words of own half.
            if (r[15:8] < 8'd13)
                addr = addr + (32'(r[7:6]) + 32'd1) * 32'd1024;  // Past the end, same index.
            if (r[31:30] == 2'b00) begin
                @(negedge aclk);              // Idle gap.
                awvalid = 1'b0;
                wvalid  = 1'b0;
                arvalid = 1'b0;
            end
            @(negedge aclk);
            awvalid  = is_wr;
            wvalid   = is_wr;
            arvalid  = !is_wr;
            awaddr   = addr;
            araddr   = addr;
            wdata    = data;
            wstrb    = strb;
            accepted = 1'b0;
            while (!accepted) begin
                #2;
                accepted = is_wr ? (awready && wready) : arready;
                if (!accepted)
                    @(negedge aclk);
            end
            exp_q.push_back(model_access(is_wr, addr, data, strb));
        end
        @(negedge aclk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        arvalid = 1'b0;
    end

    // Response side with random back-pressure.
    initial begin : check
        logic [31:0]       bp;
        logic              b_hold;
        logic              r_hold;
        axi_resp_t         b_held;
        axi_resp_t         r_held;
        logic [data_w-1:0] r_held_data;
        bready      = 1'b0;
        rready      = 1'b0;
        checked     = 0;
        errors      = 0;
        b_hold      = 1'b0;
        r_hold      = 1'b0;
        b_held      = AXI_OKAY;
        r_held      = AXI_OKAY;
        r_held_data = '0;
        @(negedge aclk);
        bp = 32'd76 + 32'(half);
        forever begin
            bp     = lcg_next(bp);
            bready = (bp[21:20] != 2'b00);    // Low about a quarter of the cycles.
            rready = (bp[23:22] != 2'b00);
            #2;
            if (!areset_n) begin
                assert (!bvalid && !rvalid && !awready && !wready && !arready) else begin
                    errors++;
                    $display("error %0t: port %0d handshake outputs active in reset",
                             $time, half);
                end
            end else begin
                if (b_hold)
                    assert (bvalid && (bresp === b_held)) else begin
                        errors++;
                        $display("error %0t: port %0d write response changed before bready",
                                 $time, half);
                    end
                if (r_hold)
                    assert (rvalid && (rresp === r_held) && (rdata === r_held_data)) else begin
                        errors++;
                        $display("error %0t: port %0d read response changed before rready",
                                 $time, half);
                    end
                if (bvalid || rvalid)
                    assert (!awready && !wready && !arready) else begin
                        errors++;
                        $display("error %0t: port %0d request ready while response pending",
                                 $time, half);
                    end
                if (bvalid && bready)
                    check_response(1'b1, bresp, '0);
                if (rvalid && rready)
                    check_response(1'b0, rresp, rdata);
                b_hold      = bvalid && !bready;
                b_held      = bresp;
                r_hold      = rvalid && !rready;
                r_held      = rresp;
                r_held_data = rdata;
            end
            @(negedge aclk);
        end
    end
endmodule

module tb_bridge_top import bridge_pkg::*; ();
    localparam int n_trans    = 150;
    localparam int max_cycles = n_trans * 20 * 2 + 200;   // 6200.

    logic              aclk;
    logic              areset_n;
    logic              s0_awvalid, s0_awready, s0_wvalid, s0_wready, s0_bvalid, s0_bready;
    logic              s0_arvalid, s0_arready, s0_rvalid, s0_rready;
    logic [addr_w-1:0] s0_awaddr, s0_araddr;
    logic [2:0]        s0_awprot, s0_arprot;
    logic [data_w-1:0] s0_wdata, s0_rdata;
    logic [strb_w-1:0] s0_wstrb;
    axi_resp_t         s0_bresp, s0_rresp;
    logic              s1_awvalid, s1_awready, s1_wvalid, s1_wready, s1_bvalid, s1_bready;
    logic              s1_arvalid, s1_arready, s1_rvalid, s1_rready;
    logic [addr_w-1:0] s1_awaddr, s1_araddr;
    logic [2:0]        s1_awprot, s1_arprot;
    logic [data_w-1:0] s1_wdata, s1_rdata;
    logic [strb_w-1:0] s1_wstrb;
    axi_resp_t         s1_bresp, s1_rresp;
    logic              done0, done1;
    int                err0, err1;

    tb_clock i_clock (.aclk(aclk), .areset_n(areset_n));

    bridge_top i_dut (
        .aclk(aclk), .areset_n(areset_n),
        .s0_awvalid(s0_awvalid), .s0_awready(s0_awready), .s0_awaddr(s0_awaddr),
        .s0_awprot(s0_awprot), .s0_wvalid(s0_wvalid), .s0_wready(s0_wready),
        .s0_wdata(s0_wdata), .s0_wstrb(s0_wstrb), .s0_bvalid(s0_bvalid),
        .s0_bready(s0_bready), .s0_bresp(s0_bresp), .s0_arvalid(s0_arvalid),
        .s0_arready(s0_arready), .s0_araddr(s0_araddr), .s0_arprot(s0_arprot),
        .s0_rvalid(s0_rvalid), .s0_rready(s0_rready), .s0_rdata(s0_rdata), .s0_rresp(s0_rresp),
        .s1_awvalid(s1_awvalid), .s1_awready(s1_awready), .s1_awaddr(s1_awaddr),
        .s1_awprot(s1_awprot), .s1_wvalid(s1_wvalid), .s1_wready(s1_wready),
        .s1_wdata(s1_wdata), .s1_wstrb(s1_wstrb), .s1_bvalid(s1_bvalid),
        .s1_bready(s1_bready), .s1_bresp(s1_bresp), .s1_arvalid(s1_arvalid),
        .s1_arready(s1_arready), .s1_araddr(s1_araddr), .s1_arprot(s1_arprot),
        .s1_rvalid(s1_rvalid), .s1_rready(s1_rready), .s1_rdata(s1_rdata), .s1_rresp(s1_rresp)
    );

    // Port 0 works in the low half, port 1 in the high half.
    axi_lite_traffic i_port0 (
        .aclk(aclk), .areset_n(areset_n), .half(1'b0), .trans_count(16'(n_trans)),
        .awvalid(s0_awvalid), .awready(s0_awready), .awaddr(s0_awaddr), .awprot(s0_awprot),
        .wvalid(s0_wvalid), .wready(s0_wready), .wdata(s0_wdata), .wstrb(s0_wstrb),
        .bvalid(s0_bvalid), .bready(s0_bready), .bresp(s0_bresp),
        .arvalid(s0_arvalid), .arready(s0_arready), .araddr(s0_araddr), .arprot(s0_arprot),
        .rvalid(s0_rvalid), .rready(s0_rready), .rdata(s0_rdata), .rresp(s0_rresp),
        .done(done0), .errors(err0)
    );

    axi_lite_traffic i_port1 (
        .aclk(aclk), .areset_n(areset_n), .half(1'b1), .trans_count(16'(n_trans)),
        .awvalid(s1_awvalid), .awready(s1_awready), .awaddr(s1_awaddr), .awprot(s1_awprot),
        .wvalid(s1_wvalid), .wready(s1_wready), .wdata(s1_wdata), .wstrb(s1_wstrb),
        .bvalid(s1_bvalid), .bready(s1_bready), .bresp(s1_bresp),
        .arvalid(s1_arvalid), .arready(s1_arready), .araddr(s1_araddr), .arprot(s1_arprot),
        .rvalid(s1_rvalid), .rready(s1_rready), .rdata(s1_rdata), .rresp(s1_rresp),
        .done(done1), .errors(err1)
    );

    // Run length guard and final report.
    initial begin : supervise
        int cycles;
        cycles = 0;
        @(posedge areset_n);
        while (!(done0 && done1) && (cycles < max_cycles)) begin
            @(posedge aclk);
            cycles++;
        end
        $display("Errors: port 0 %0d, port 1 %0d, total %0d after %0d cycles",
                 err0, err1, err0 + err1, cycles);
        if (!(done0 && done1)) begin
            $display("Timeout: transactions still open after %0d cycles (port 0 %0b, port 1 %0b)",
                     cycles, done0, done1);
            $display("Done: errors found");
        end else if (err0 + err1 == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end
endmodule

`default_nettype wire

/* sim.f */
common/bridge_pkg.sv
axi_to_avalon/axi_to_avalon_bridge.sv
logic/avalon_arbiter.sv
logic/avalon_memory.sv
logic/bridge_top.sv
bench/tb_clock.sv
bench/tb_bridge_top.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_bridge_top -f sim.f --Mdir obj_dir -o tb_bridge_top
./obj_dir/tb_bridge_top > sim.log 2>&1 || true
cat sim.log
if grep -qx "Done: no errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
